/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module t900_tb

sim:
	verilator --binary --timing --assert -f build.f --top-module t900_tb \
		-Mdir obj_dir -o t900_sim
	./obj_dir/t900_sim | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
logic/t900_pkg.sv
logic/t900_fetch.sv
logic/t900_ctrl.sv
logic/t900_regs.sv
logic/t900_alu.sv
logic/t900_idx.sv
logic/t900_core.sv
verification/t900_core_properties.sv
verification/t900_tb.sv

/* logic/t900_alu.sv */
// ----------------------------------------
// t900 move ALU
// immediate or register source to a write
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module t900_alu (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  t900_pkg::alu_ctrl_t alu,
    output t900_pkg::reg_code_t src_sel,
    input  logic [31:0]         src_data,
    output t900_pkg::reg_wr_t   wr
);

    logic [31:0] lane;
    logic [31:0] reg_val;

    assign src_sel = alu.src;

    always_comb begin
        lane = src_data >> {alu.src[1:0], 3'b000};
        case (alu.width)
            t900_pkg::W_BYTE: reg_val = {24'd0, lane[7:0]};
            t900_pkg::W_WORD: reg_val = alu.src[1] ? {16'd0, src_data[31:16]}
                                                   : {16'd0, src_data[15:0]};
            default:          reg_val = src_data;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr <= '0;
        end else begin
            wr <= '0;   // single clock write strobe, all zero when idle
            if (cen && alu.op == t900_pkg::ALU_MOVE && !alu.wait_imm) begin
                wr.we    <= 1'b1;
                wr.dst   <= alu.dst;
                wr.width <= alu.width;
                wr.data  <= alu.smux ? alu.imm : reg_val;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/t900_core.sv */
// ----------------------------------------
// t900 core slice
// fetch, decode, index, move ALU and registers
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module t900_core #(
    parameter int ROM_AW = 12,
    parameter int RAM_AW = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    output logic [ROM_AW-1:0]   rom_addr,
    input  logic [7:0]          rom_data,
    output logic [RAM_AW-1:0]   ram_addr,
    output logic                ram_rd,
    input  logic [31:0]         ram_data,
    output t900_pkg::reg_wr_t   reg_wr,
    input  t900_pkg::reg_code_t dbg_sel,
    output logic [31:0]         dbg_data
);

    logic [31:0]         op;
    logic                op_ok;
    logic [1:0]          fetched;
    logic                idx_en;
    logic                idx_ok;
    logic                ldram_en;
    t900_pkg::reg_code_t ld_dst;
    t900_pkg::width_t    ld_width;
    t900_pkg::alu_ctrl_t alu;
    t900_pkg::reg_code_t alu_sel;
    t900_pkg::reg_code_t idx_sel;
    logic [31:0]         alu_data;
    logic [31:0]         idx_data;
    t900_pkg::reg_wr_t   alu_wr;
    t900_pkg::reg_wr_t   idx_wr;

    // the decoder never lets both units write in the same cycle
    assign reg_wr = t900_pkg::reg_wr_t'(alu_wr | idx_wr);

    t900_fetch #(.ROM_AW(ROM_AW)) i_fetch (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .fetched  (fetched),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .op       (op),
        .op_ok    (op_ok)
    );

    t900_ctrl i_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op       (op),
        .op_ok    (op_ok),
        .idx_ok   (idx_ok),
        .fetched  (fetched),
        .idx_en   (idx_en),
        .ldram_en (ldram_en),
        .ld_dst   (ld_dst),
        .ld_width (ld_width),
        .alu      (alu)
    );

    t900_idx #(.RAM_AW(RAM_AW)) i_idx (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .idx_en   (idx_en),
        .op       (op),
        .idx_ok   (idx_ok),
        .rd_sel   (idx_sel),
        .rd_data  (idx_data),
        .ldram_en (ldram_en),
        .ld_dst   (ld_dst),
        .ld_width (ld_width),
        .ram_addr (ram_addr),
        .ram_rd   (ram_rd),
        .ram_data (ram_data),
        .wr       (idx_wr)
    );

    t900_alu i_alu (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .alu      (alu),
        .src_sel  (alu_sel),
        .src_data (alu_data),
        .wr       (alu_wr)
    );

    t900_regs i_regs (
        .clk      (clk),
        .rst      (rst),
        .wr       (reg_wr),
        .rd_a_sel (alu_sel),
        .rd_b_sel (idx_sel),
        .rd_a     (alu_data),
        .rd_b     (idx_data),
        .dbg_sel  (dbg_sel),
        .dbg_data (dbg_data)
    );

endmodule

`default_nettype wire

/* logic/t900_ctrl.sv */
// ----------------------------------------
// t900 decoder
// register load opcodes to ALU, index and load controls
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module t900_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic [31:0]           op,
    input  logic                  op_ok,
    input  logic                  idx_ok,
    output logic [1:0]            fetched,
    output logic                  idx_en,
    output logic                  ldram_en,
    output t900_pkg::reg_code_t   ld_dst,
    output t900_pkg::width_t      ld_width,
    output t900_pkg::alu_ctrl_t   alu
);

    t900_pkg::phase_t    phase;
    t900_pkg::phase_t    nx_phase;
    t900_pkg::alu_ctrl_t nx_alu;
    logic                nx_idx_en;
    logic                nx_ldram_en;
    t900_pkg::reg_code_t nx_ld_dst;
    t900_pkg::width_t    nx_ld_width;

    always_comb begin
        fetched     = 2'd0;
        nx_phase    = phase;
        nx_alu      = alu;
        nx_alu.op   = t900_pkg::ALU_NOP;    // move is a one cycle strobe
        nx_idx_en   = idx_en;
        nx_ldram_en = 1'b0;
        nx_ld_dst   = ld_dst;
        nx_ld_width = ld_width;
        if (op_ok) begin
            case (phase)
                t900_pkg::FETCH: begin
                    casez (op[7:0])
                        8'b0010_0???, 8'b0011_0???, 8'b0100_0???: begin // LD R,#
                            nx_alu.dst      = t900_pkg::expand_reg(op[2:0]);
                            nx_alu.width    = t900_pkg::width_t'({op[6], op[4]});
                            nx_alu.imm      = {24'd0, op[15:8]};
                            nx_alu.op       = t900_pkg::ALU_MOVE;
                            nx_alu.smux     = 1'b1;
                            nx_alu.wait_imm = 1'b0;
                            fetched         = 2'd2;
                            if (nx_alu.width != t900_pkg::W_BYTE) begin
                                nx_alu.wait_imm = 1'b1;
                                nx_phase        = t900_pkg::FILL_IMM;
                            end
                        end
                        8'b100?_0???, 8'b1010_0???: begin   // (R) memory prefix
                            nx_idx_en   = 1'b1;
                            nx_ld_width = t900_pkg::width_t'(op[5:4]);
                            nx_phase    = t900_pkg::IDX;
                        end
                        8'b110?_1???, 8'b1110_1???: begin   // short r prefix
                            nx_alu.dst   = t900_pkg::expand_reg(op[2:0]);
                            nx_alu.width = t900_pkg::width_t'(op[5:4]);
                            fetched      = 2'd1;
                            nx_phase     = t900_pkg::EXEC;
                        end
                        8'b110?_0111, 8'b1110_0111: begin   // full register code
                            nx_alu.dst   = op[15:8];
                            nx_alu.width = t900_pkg::width_t'(op[5:4]);
                            fetched      = 2'd2;
                            nx_phase     = t900_pkg::EXEC;
                        end
                        default: fetched = 2'd1;            // illegal, skip it
                    endcase
                end
                t900_pkg::IDX: begin
                    if (idx_ok) begin
                        nx_idx_en = 1'b0;
                        if (op[15:11] == 5'b0010_0) begin   // LD R,(mem)
                            nx_ldram_en = 1'b1;
                            nx_ld_dst   = t900_pkg::expand_reg(op[10:8]);
                            nx_phase    = t900_pkg::LD_RAM;
                        end else begin
                            fetched  = 2'd1;
                            nx_phase = t900_pkg::FETCH;
                        end
                    end
                end
                t900_pkg::LD_RAM: begin
                    // hold the queue until the load is on its way to the registers
                    if (!ldram_en) begin
                        fetched  = 2'd2;
                        nx_phase = t900_pkg::FETCH;
                    end
                end
                t900_pkg::EXEC: begin
                    nx_phase = t900_pkg::FETCH;
                    fetched  = 2'd1;
                    casez (op[7:0])
                        8'b1000_1???: begin                 // LD R,r
                            nx_alu.src  = alu.dst;
                            nx_alu.dst  = t900_pkg::expand_reg(op[2:0]);
                            nx_alu.op   = t900_pkg::ALU_MOVE;
                            nx_alu.smux = 1'b0;
                        end
                        8'b1001_1???: begin                 // LD r,R
                            nx_alu.src  = t900_pkg::expand_reg(op[2:0]);
                            nx_alu.op   = t900_pkg::ALU_MOVE;
                            nx_alu.smux = 1'b0;
                        end
                        8'b1010_1???: begin                 // LD r,#3
                            nx_alu.imm  = {29'd0, op[2:0]};
                            nx_alu.op   = t900_pkg::ALU_MOVE;
                            nx_alu.smux = 1'b1;
                        end
                        8'b0000_0011: begin                 // LD r,#
                            nx_alu.imm  = {24'd0, op[15:8]};
                            nx_alu.op   = t900_pkg::ALU_MOVE;
                            nx_alu.smux = 1'b1;
                            fetched     = 2'd2;
                            if (alu.width != t900_pkg::W_BYTE) begin
                                nx_alu.wait_imm = 1'b1;
                                nx_phase        = t900_pkg::FILL_IMM;
                            end
                        end
                        default: ;
                    endcase
                end
                t900_pkg::FILL_IMM: begin
                    nx_alu.op       = t900_pkg::ALU_MOVE;
                    nx_alu.wait_imm = 1'b0;
                    nx_phase        = t900_pkg::FETCH;
                    if (alu.width == t900_pkg::W_WORD) begin
                        nx_alu.imm[31:8] = {16'd0, op[7:0]};
                        fetched          = 2'd1;
                    end else begin
                        nx_alu.imm[31:8] = op[23:0];
                        fetched          = 2'd3;
                    end
                end
                default: nx_phase = t900_pkg::FETCH;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= t900_pkg::FETCH;
            alu      <= '0;
            idx_en   <= 1'b0;
            ldram_en <= 1'b0;
            ld_dst   <= '0;
            ld_width <= t900_pkg::W_BYTE;
        end else if (cen) begin
            phase    <= nx_phase;
            alu      <= nx_alu;
            idx_en   <= nx_idx_en;
            ldram_en <= nx_ldram_en;
            ld_dst   <= nx_ld_dst;
            ld_width <= nx_ld_width;
        end
    end

endmodule

`default_nettype wire

/* logic/t900_fetch.sv */
// ----------------------------------------
// t900 fetch unit
// four byte opcode window refilled from the program ROM
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module t900_fetch #(
    parameter int ROM_AW = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [1:0]        fetched,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic [7:0]        rom_data,
    output logic [31:0]       op,
    output logic              op_ok
);

    logic [31:0]       queue;   // byte 0 at the front
    logic [2:0]        count;
    logic [ROM_AW-1:0] ptr;     // next ROM byte to request
    logic              pend;    // rom_data holds the byte at ptr-1
    logic [2:0]        keep;
    logic [2:0]        fill;
    logic [31:0]       shifted;

    assign op    = queue;
    assign op_ok = count == 3'd4;

    // while stalled, keep showing the address of the byte in flight
    assign rom_addr = (pend && !cen) ? ptr - 1'b1 : ptr;

    always_comb begin
        keep    = op_ok ? count - {1'b0, fetched} : count;
        shifted = op_ok ? queue >> {fetched, 3'b000} : queue;
        fill    = keep + {2'b00, pend};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= 3'd0;
            ptr   <= '0;
            pend  <= 1'b0;
        end else if (cen) begin
            count <= fill;
            pend  <= fill != 3'd4;          // request only if it will fit
            if (fill != 3'd4) begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            queue <= shifted;
            if (pend) begin
                queue[{keep[1:0], 3'b000} +: 8] <= rom_data;    // append at the back
            end
        end
    end

endmodule

`default_nettype wire

/* logic/t900_idx.sv */
// ----------------------------------------
// t900 index unit
// register indirect address and data RAM load
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module t900_idx #(
    parameter int RAM_AW = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                idx_en,
    input  logic [31:0]         op,
    output logic                idx_ok,
    output t900_pkg::reg_code_t rd_sel,
    input  logic [31:0]         rd_data,
    input  logic                ldram_en,
    input  t900_pkg::reg_code_t ld_dst,
    input  t900_pkg::width_t    ld_width,
    output logic [RAM_AW-1:0]   ram_addr,
    output logic                ram_rd,
    input  logic [31:0]         ram_data,
    output t900_pkg::reg_wr_t   wr
);

    logic        rd_pend;   // RAM data valid this cycle
    logic [31:0] ld_val;

    assign rd_sel = t900_pkg::expand_reg(op[2:0]);  // prefix byte still at the front

    always_comb begin
        case (ld_width)
            t900_pkg::W_BYTE: ld_val = {24'd0, ram_data[7:0]};
            t900_pkg::W_WORD: ld_val = {16'd0, ram_data[15:0]};
            default:          ld_val = ram_data;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx_ok  <= 1'b0;
            ram_rd  <= 1'b0;
            rd_pend <= 1'b0;
            wr      <= '0;
        end else begin
            wr <= '0;   // all zero when idle, merged with the ALU write
            if (cen) begin
                idx_ok  <= idx_en && !idx_ok;  // one pulse per request
                ram_rd  <= ldram_en;
                rd_pend <= ram_rd;
                if (rd_pend) begin
                    wr.we    <= 1'b1;
                    wr.dst   <= ld_dst;
                    wr.width <= ld_width;
                    wr.data  <= ld_val;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && idx_en && !idx_ok) begin
            ram_addr <= rd_data[RAM_AW-1:0];
        end
    end

endmodule

`default_nettype wire

/* logic/t900_pkg.sv */
// ----------------------------------------
// t900 shared types
// decoder phases, ALU codes, widths and the write bundle
// ----------------------------------------
`default_nettype none

package t900_pkg;

    typedef enum logic [2:0] {
        FETCH,
        IDX,
        LD_RAM,
        EXEC,
        FILL_IMM
    } phase_t;

    typedef enum logic [1:0] {
        ALU_NOP,
        ALU_MOVE
    } alu_op_t;

    typedef enum logic [1:0] {
        W_BYTE,
        W_WORD,
        W_LONG
    } width_t;

    // bits 4:2 pick the 32-bit register, bits 1:0 the byte lane
    typedef logic [7:0] reg_code_t;

    typedef struct packed {
        alu_op_t     op;
        logic        smux;      // 1 selects the immediate
        logic        wait_imm;  // upper immediate bytes still missing
        logic [31:0] imm;
        reg_code_t   src;
        reg_code_t   dst;
        width_t      width;
    } alu_ctrl_t;

    typedef struct packed {
        logic        we;
        reg_code_t   dst;
        width_t      width;
        logic [31:0] data;
    } reg_wr_t;

    // short 3-bit code to a current bank register, lane 0
    function automatic reg_code_t expand_reg(input logic [2:0] short_code);
        return {3'b111, short_code, 2'b00};
    endfunction

endpackage

`default_nettype wire

/* logic/t900_regs.sv */
// ----------------------------------------
// t900 register file
// eight current bank registers, lane writes
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module t900_regs (
    input  logic                clk,
    input  logic                rst,
    input  t900_pkg::reg_wr_t   wr,
    input  t900_pkg::reg_code_t rd_a_sel,
    input  t900_pkg::reg_code_t rd_b_sel,
    output logic [31:0]         rd_a,
    output logic [31:0]         rd_b,
    input  t900_pkg::reg_code_t dbg_sel,
    output logic [31:0]         dbg_data
);

    logic [31:0] xr [8];    // XWA .. XSP
    logic        cur_bank;

    assign cur_bank = wr.dst[7:5] == 3'b111;   // lower codes are banked, not kept

    // banked codes read as zero
    assign rd_a     = rd_a_sel[7:5] == 3'b111 ? xr[rd_a_sel[4:2]] : 32'd0;
    assign rd_b     = rd_b_sel[7:5] == 3'b111 ? xr[rd_b_sel[4:2]] : 32'd0;
    assign dbg_data = dbg_sel[7:5] == 3'b111 ? xr[dbg_sel[4:2]] : 32'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xr <= '{default: 32'd0};
        end else if (wr.we && cur_bank) begin
            case (wr.width)
                t900_pkg::W_BYTE: begin
                    xr[wr.dst[4:2]][{wr.dst[1:0], 3'b000} +: 8] <= wr.data[7:0];
                end
                t900_pkg::W_WORD: begin
                    xr[wr.dst[4:2]][{wr.dst[1], 4'b0000} +: 16] <= wr.data[15:0];
                end
                default: xr[wr.dst[4:2]] <= wr.data;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verification/t900_core_properties.sv */
// ----------------------------------------
// t900 core control timing checks
// bound into the core top level
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module t900_core_properties (
    input logic                clk,
    input logic                rst,
    input logic                cen,
    input logic                idx_en,
    input logic                idx_ok,
    input logic                ldram_en,
    input logic                ram_rd,
    input logic                op_ok,
    input logic [1:0]          fetched,
    input t900_pkg::alu_ctrl_t alu,
    input t900_pkg::reg_wr_t   reg_wr
);

    idx_hold: assert property (@(posedge clk) disable iff (rst)
        idx_en && !idx_ok && cen |=> idx_en && idx_ok)
        else $error("idx_en dropped or idx_ok missing after one enabled cycle");

    load_read: assert property (@(posedge clk) disable iff (rst)
        ldram_en && cen |=> ram_rd)
        else $error("ldram_en not followed by ram_rd");

    no_partial_write: assert property (@(posedge clk) disable iff (rst)
        alu.wait_imm |-> !reg_wr.we)
        else $error("register write while the immediate is incomplete");

    consume_refill: assert property (@(posedge clk) disable iff (rst)
        cen && fetched != 2'd0 |=> !op_ok)
        else $error("opcode window still full after bytes were consumed");

endmodule

bind t900_core t900_core_properties i_props (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .idx_en   (idx_en),
    .idx_ok   (idx_ok),
    .ldram_en (ldram_en),
    .ram_rd   (ram_rd),
    .op_ok    (op_ok),
    .fetched  (fetched),
    .alu      (alu),
    .reg_wr   (reg_wr)
);

`default_nettype wire

/* verification/t900_tb.sv */
// ----------------------------------------
// t900 core testbench
// random load programs checked against a reference model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module t900_tb;

    localparam int ROM_AW  = 12;
    localparam int RAM_AW  = 10;
    localparam int CYCLE   = 100;
    localparam int N_INSTR = 360;   // all runs together

    logic                clk;
    logic                rst;
    logic                cen;
    logic [ROM_AW-1:0]   rom_addr;
    logic [7:0]          rom_data = 8'd0;
    logic [RAM_AW-1:0]   ram_addr;
    logic                ram_rd;
    logic [31:0]         ram_data = 32'd0;
    t900_pkg::reg_wr_t   reg_wr;
    t900_pkg::reg_code_t dbg_sel;
    logic [31:0]         dbg_data;

    logic [7:0]          rom [2**ROM_AW];
    logic [31:0]         model [8];     // expected XWA .. XSP
    t900_pkg::reg_wr_t   exp_q [$];
    logic [15:0]         lfsr;
    int                  gen_pc;
    int                  prog_len;
    int                  checks;
    int                  errors;

    t900_core #(.ROM_AW(ROM_AW), .RAM_AW(RAM_AW)) i_dut (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .ram_addr (ram_addr),
        .ram_rd   (ram_rd),
        .ram_data (ram_data),
        .reg_wr   (reg_wr),
        .dbg_sel  (dbg_sel),
        .dbg_data (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CYCLE / 2) clk = ~clk;
    end

    function automatic logic [31:0] ram_value(input logic [RAM_AW-1:0] a);
        return {~a[5:0], a, a ^ 10'h2b5, 6'h19};
    endfunction

    always @(posedge clk) begin
        rom_data <= rom[rom_addr];  // one cycle read
        if (ram_rd) begin
            ram_data <= ram_value(ram_addr);
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [1:0] rand_width();
        logic [1:0] w;
        w = 2'(rand_bits(2));
        return (w == 2'd3) ? 2'd2 : w;
    endfunction

    function automatic void put_byte(input logic [7:0] b);
        rom[gen_pc[ROM_AW-1:0]] = b;
        gen_pc++;
    endfunction

    function automatic int imm_len(input logic [1:0] w);
        return (w == 2'd0) ? 1 : (w == 2'd1) ? 2 : 4;
    endfunction

    function automatic void put_imm(input logic [1:0] w);
        for (int i = 0; i < imm_len(w); i++) begin
            put_byte(8'(rand_bits(8)));
        end
    endfunction

    // short register prefix, or full code with a banked code now and then
    function automatic void put_prefix(input logic [1:0] w);
        logic [7:0] base;
        base = 8'hc0 + {2'b00, w, 4'h0};
        if (next_bit()) begin
            put_byte(base | 8'h08 | {5'd0, 3'(rand_bits(3))});
        end else begin
            put_byte(base | 8'h07);
            put_byte(rand_bits(2) == 0 ? 8'(rand_bits(8)) : {3'b111, 5'(rand_bits(5))});
        end
    endfunction

    function automatic void put_instr(input int kind);
        logic [1:0] w;
        w = rand_width();
        case (kind)
            0: begin
                put_byte(8'h20 + {2'b00, w, 4'h0} + {5'd0, 3'(rand_bits(3))});
                put_imm(w);
            end
            1: begin
                put_prefix(w);
                put_byte((next_bit() ? 8'h98 : 8'h88) | {5'd0, 3'(rand_bits(3))});
            end
            2: begin
                put_prefix(w);
                if (next_bit()) begin
                    put_byte(8'ha8 | {5'd0, 3'(rand_bits(3))});
                end else begin
                    put_byte(8'h03);
                    put_imm(w);
                end
            end
            default: begin
                put_byte(8'h80 + {2'b00, w, 4'h0} + {5'd0, 3'(rand_bits(3))});
                put_byte(8'h20 | {5'd0, 3'(rand_bits(3))});
            end
        endcase
    endfunction

    // kind 4 mixes all forms; every kind but 0 starts with long loads of all registers
    function automatic void build_program(input int kind, input int n);
        int k;
        gen_pc = 0;
        if (kind != 0) begin
            for (int r = 0; r < 8; r++) begin
                put_byte(8'h40 + 8'(r));
                put_imm(2'd2);
            end
        end
        for (int i = 0; i < n; i++) begin
            k = (kind == 4) ? int'(rand_bits(2)) : kind;
            put_instr(k);
        end
        prog_len = gen_pc;
        for (int a = gen_pc; a < 2**ROM_AW; a++) begin
            rom[a[ROM_AW-1:0]] = {3'b000, a[4:0] ^ a[9:5] ^ {3'b000, a[11:10]}};  // illegal ops
        end
    endfunction

    function automatic logic [7:0] rom_at(input int a);
        return rom[a[ROM_AW-1:0]];
    endfunction

    function automatic logic [31:0] rom_imm(input int a, input logic [1:0] w);
        if (w == 2'd0) return {24'd0, rom_at(a)};
        if (w == 2'd1) return {16'd0, rom_at(a + 1), rom_at(a)};
        return {rom_at(a + 3), rom_at(a + 2), rom_at(a + 1), rom_at(a)};
    endfunction

    function automatic t900_pkg::reg_code_t short_reg(input logic [2:0] r);
        return {3'b111, r, 2'b00};
    endfunction

    function automatic logic [31:0] read_model(input t900_pkg::reg_code_t c);
        return (c[7:5] == 3'b111) ? model[c[4:2]] : 32'd0;
    endfunction

    function automatic logic [31:0] source_value(input t900_pkg::reg_code_t c,
                                                 input logic [1:0] w);
        logic [31:0] v;
        v = read_model(c);
        if (w == 2'd0) return {24'd0, v[{c[1:0], 3'b000} +: 8]};
        if (w == 2'd1) return c[1] ? {16'd0, v[31:16]} : {16'd0, v[15:0]};
        return v;
    endfunction

    function automatic void note_write(input t900_pkg::reg_code_t dst, input logic [1:0] w,
                                       input logic [31:0] d);
        t900_pkg::reg_wr_t e;
        e.we    = 1'b1;
        e.dst   = dst;
        e.width = t900_pkg::width_t'(w);
        e.data  = d;
        exp_q.push_back(e);
        if (dst[7:5] == 3'b111) begin  // banked codes are dropped
            case (w)
                2'd0:    model[dst[4:2]][{dst[1:0], 3'b000} +: 8] = d[7:0];
                2'd1:    model[dst[4:2]][{dst[1], 4'b0000} +: 16] = d[15:0];
                default: model[dst[4:2]] = d;
            endcase
        end
    endfunction

    function automatic void run_reference(input int len);
        int                  pc;
        logic [7:0]          b0;
        logic [7:0]          b1;
        logic [1:0]          w;
        logic [31:0]         v;
        t900_pkg::reg_code_t pre;
        logic                has_pre;
        pc = 0;
        while (pc < len) begin
            b0      = rom_at(pc);
            w       = b0[5:4];
            has_pre = 1'b0;
            pre     = '0;
            if (b0[7:3] inside {5'b00100, 5'b00110, 5'b01000}) begin
                w = {b0[6], b0[4]};
                note_write(short_reg(b0[2:0]), w, rom_imm(pc + 1, w));
                pc += 1 + imm_len(w);
            end else if (b0[7:3] inside {5'b10000, 5'b10010, 5'b10100}) begin
                b1 = rom_at(pc + 1);
                v  = read_model(short_reg(b0[2:0]));
                v  = ram_value(v[RAM_AW-1:0]);
                v  = (w == 2'd0) ? {24'd0, v[7:0]} : (w == 2'd1) ? {16'd0, v[15:0]} : v;
                note_write(short_reg(b1[2:0]), w, v);
                pc += 2;
            end else if (b0[7:3] inside {5'b11001, 5'b11011, 5'b11101}) begin
                pre     = short_reg(b0[2:0]);
                has_pre = 1'b1;
                pc += 1;
            end else if (b0 inside {8'hc7, 8'hd7, 8'he7}) begin
                pre     = rom_at(pc + 1);
                has_pre = 1'b1;
                pc += 2;
            end else begin
                pc += 1;
            end
            if (has_pre) begin
                b1 = rom_at(pc);
                pc += 1;
                if (b1[7:3] == 5'b10001) begin
                    note_write(short_reg(b1[2:0]), w, source_value(pre, w));
                end else if (b1[7:3] == 5'b10011) begin
                    note_write(pre, w, source_value(short_reg(b1[2:0]), w));
                end else if (b1[7:3] == 5'b10101) begin
                    note_write(pre, w, {29'd0, b1[2:0]});
                end else if (b1 == 8'h03) begin
                    note_write(pre, w, rom_imm(pc, w));
                    pc += imm_len(w);
                end
            end
        end
    endfunction

    always @(negedge clk) begin
        t900_pkg::reg_wr_t e;
        if (!rst && reg_wr.we) begin
            if (exp_q.size() == 0) begin
                $display("unexpected register write at %0t, the reference has none left",
                         $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checks++;
                assert (reg_wr == e) else begin
                    $display("ERROR %0t: write %h/%0d/%h, expected %h/%0d/%h", $time,
                             reg_wr.dst, reg_wr.width, reg_wr.data, e.dst, e.width, e.data);
                    errors++;
                end
            end
        end
    end

    task automatic run_program(input string name, input logic cen_rand);
        int settle;
        int errs_before;
        errs_before = errors;
        model       = '{default: 32'd0};
        exp_q.delete();
        run_reference(prog_len);
        @(posedge clk);
        rst <= 1'b1;
        cen <= 1'b1;
        repeat (3) @(posedge clk);
        rst    <= 1'b0;
        settle = 0;
        while (settle < 40) begin  // catch stray writes after the last one
            @(posedge clk);
            cen <= cen_rand ? next_bit() : 1'b1;
            if (exp_q.size() == 0) begin
                settle++;
            end
        end
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            dbg_sel <= {3'b111, 3'(i), 2'b00};
            @(negedge clk);
            checks++;
            assert (dbg_data == model[i]) else begin
                $display("ERROR %0t: register %0d holds %h, expected %h", $time, i,
                         dbg_data, model[i]);
                errors++;
            end
        end
        $display("%s: %0d errors", name, errors - errs_before);
    endtask

    initial begin
        #(N_INSTR * 20 * CYCLE);
        $display("timeout: the tests did not finish within %0d cycles", N_INSTR * 20);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        cen     = 1'b1;
        dbg_sel = '0;
        lfsr    = 16'd31400;
        checks  = 0;
        errors  = 0;
        build_program(0, 24);
        run_program("test 1 immediate loads", 1'b0);
        build_program(1, 24);
        run_program("test 2 register moves", 1'b0);
        build_program(2, 24);
        run_program("test 3 prefixed immediates", 1'b0);
        build_program(3, 24);
        run_program("test 4 memory loads", 1'b0);
        run_program("test 4 memory loads with cen toggled", 1'b1);
        build_program(4, 200);
        run_program("test 5 random mixed program", 1'b0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
